//--- wb_soc.f
common/wb_soc_pkg.sv
design/bus_arbiter.sv
design/addr_decoder.sv
design/wb_ram.sv
design/sim_ctrl.sv
timer/riscv_timer.sv
design/wb_soc.sv
tests/wb_soc_assert.sv
tests/wb_soc_tb.sv

//--- Makefile
TOP   := wb_soc_tb
FLIST := wb_soc.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)
	verilator --lint-only --top-module wb_soc common/wb_soc_pkg.sv \
		design/bus_arbiter.sv design/addr_decoder.sv design/wb_ram.sv \
		design/sim_ctrl.sv timer/riscv_timer.sv design/wb_soc.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- tests/wb_soc_tb.sv
`timescale 1ns/1ps

module wb_soc_tb import wb_soc_pkg::*; ();

   localparam int MEM_DEPTH = 16384;
   localparam bit IBUS      = 1'b0;
   localparam bit DBUS      = 1'b1;

   typedef struct packed {
      bit    use_dbus;
      logic  we;
      addr_t adr;
      data_t dat;
      sel_t  sel;
      data_t exp;   // only looked at for reads
   } stim_t;

   logic    i_wb_clk;
   logic    i_arst_n;
   addr_t   i_ibus_adr;
   logic    i_ibus_cyc;
   logic    i_ibus_stb;
   wb_s2m_t o_ibus;
   wb_m2s_t i_dbus;
   wb_s2m_t o_dbus;
   logic    o_timer_irq;
   char_t   o_print_char;
   logic    o_print_valid;
   logic    o_halt;

   stim_t       stim [$];
   data_t       ram_model [int];   // expected RAM contents, one entry per word
   data_t       lcg_state    = 32'd21;
   data_t       print_word   = 32'hCAFE_BA41;
   int unsigned cycles       = 0;
   int unsigned limit        = 400;
   int          pass_count   = 0;
   int          fail_count   = 0;
   int          print_pulses = 0;
   char_t       last_char    = '0;

   wb_soc #(.MEM_DEPTH (MEM_DEPTH)) wb_soc_i (.*);

   initial begin
      i_wb_clk = 1'b0;
      forever #20 i_wb_clk = ~i_wb_clk;
   end

   initial begin
      while (cycles < limit) begin
         @(posedge i_wb_clk);
         cycles++;
      end
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
   end

   // the pulse is one cycle wide, so one falling edge sees it
   always @(negedge i_wb_clk) begin
      if (o_print_valid) begin
         print_pulses++;
         last_char = o_print_char;
      end
   end

   // ************************************************************
   // helpers
   // ************************************************************

   function automatic data_t next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic addr_t reg_addr(logic [3:0] region, logic [1:0] offset);
      return {region, 24'd0, offset, 2'b00};
   endfunction

   function automatic int word_of(addr_t adr);
      return int'((adr >> 2) % MEM_DEPTH);   // the RAM wraps at its depth
   endfunction

   task automatic add_write(input bit use_dbus, input addr_t adr, input data_t dat,
                            input sel_t sel);
      data_t word;
      if (adr[31:28] == MAP_RAM) begin
         word = ram_model.exists(word_of(adr)) ? ram_model[word_of(adr)] : 'x;
         for (int b = 0; b < 4; b++) begin
            if (sel[b]) word[8*b +: 8] = dat[8*b +: 8];
         end
         ram_model[word_of(adr)] = word;
      end
      stim.push_back('{use_dbus, 1'b1, adr, dat, sel, 32'd0});
   endtask

   task automatic add_read(input bit use_dbus, input addr_t adr, input data_t exp);
      stim.push_back('{use_dbus, 1'b0, adr, 32'd0, 4'b1111, exp});
   endtask

   task automatic add_ram_read(input bit use_dbus, input addr_t adr);
      add_read(use_dbus, adr, ram_model[word_of(adr)]);
   endtask

   task automatic build_stimulus();
      addr_t ram0;
      addr_t adr;
      ram0 = {MAP_RAM, 28'd0};
      add_write(DBUS, ram0, 32'h1122_3344, 4'b1111);
      add_write(DBUS, ram0, 32'hAABB_CCDD, 4'b0101);
      add_write(DBUS, ram0 + 4, 32'h0000_0000, 4'b1111);
      add_write(DBUS, ram0 + 4, 32'h5566_7788, 4'b1100);
      add_write(DBUS, ram0 + 4, 32'h0000_9900, 4'b0010);
      add_ram_read(IBUS, ram0);
      add_ram_read(DBUS, ram0 + 4);
      add_write(DBUS, ram0, 32'hEE00_0000, 4'b1000);
      add_ram_read(DBUS, ram0);
      add_ram_read(IBUS, ram0 + 4);
      add_ram_read(IBUS, ram0 + 4 * MEM_DEPTH);   // lands on word 0 again
      add_read(DBUS, reg_addr(MAP_SIM, SIM_HALT), 32'd0);
      add_write(DBUS, reg_addr(MAP_SIM, SIM_PRINT), print_word, 4'b1111);
      add_write(DBUS, reg_addr(MAP_SIM, SIM_HALT), 32'd1, 4'b1111);
      add_read(DBUS, reg_addr(MAP_SIM, SIM_HALT), 32'd1);
      add_read(IBUS, reg_addr(MAP_SIM, SIM_HALT), 32'd1);
      add_read(IBUS, reg_addr(4'hB, 2'd0), 32'd0);   // nothing mapped there
      for (int i = 0; i < 32; i++) begin
         adr = ram0 + 4 * ((next_random() >> 16) % MEM_DEPTH);
         add_write(DBUS, adr, next_random(), 4'b1111);
         add_ram_read((i % 2 == 1) ? IBUS : DBUS, adr);
      end
   endtask

   // ************************************************************
   // bus cycles and checks
   // ************************************************************

   task automatic bus_cycle(input bit use_dbus, input logic we, input addr_t adr,
                            input data_t dat, input sel_t sel,
                            output data_t rdat, output time t_done);
      @(posedge i_wb_clk);
      #2;
      if (use_dbus) begin
         i_dbus = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      end else begin
         i_ibus_adr = adr;
         i_ibus_cyc = 1'b1;
         i_ibus_stb = 1'b1;
      end
      do begin
         @(negedge i_wb_clk);
      end while (!(use_dbus ? o_dbus.ack : o_ibus.ack));
      rdat   = use_dbus ? o_dbus.dat : o_ibus.dat;
      t_done = $time;
      @(posedge i_wb_clk);
      #2;
      if (use_dbus) begin
         i_dbus.cyc = 1'b0;
         i_dbus.stb = 1'b0;
      end else begin
         i_ibus_cyc = 1'b0;
         i_ibus_stb = 1'b0;
      end
   endtask

   task automatic check_data(input string what, input data_t exp, input data_t got);
      if (got !== exp) begin
         fail_count++;
         $display("MISMATCH at time %0t: %s expected %h, got %h", $time, what, exp, got);
      end else begin
         pass_count++;
         $display("ok: %s = %h", what, got);
      end
   endtask

   task automatic check_char(input string what, input char_t exp, input char_t got);
      if (got !== exp) begin
         fail_count++;
         $display("MISMATCH at time %0t: %s expected %h, got %h", $time, what, exp, got);
      end else begin
         pass_count++;
         $display("ok: %s = %h", what, got);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic got);
      if (got !== exp) begin
         fail_count++;
         $display("MISMATCH at time %0t: %s expected %b, got %b", $time, what, exp, got);
      end else begin
         pass_count++;
         $display("ok: %s = %b", what, got);
      end
   endtask

   // dbus writes while ibus reads the same word, the winner decides what ibus sees
   task automatic run_pair(input data_t wdat, input addr_t adr);
      data_t db_rdat;
      data_t ib_rdat;
      time   db_done;
      time   ib_done;
      fork
         bus_cycle(DBUS, 1'b1, adr, wdat, 4'b1111, db_rdat, db_done);
         bus_cycle(IBUS, 1'b0, adr, 32'd0, 4'b1111, ib_rdat, ib_done);
      join
      check_flag($sformatf("dbus served first at %h", adr), 1'b1, db_done < ib_done);
      check_data($sformatf("ibus read after dbus write at %h", adr), wdat, ib_rdat);
   endtask

   // ************************************************************
   // main sequence
   // ************************************************************

   initial begin
      data_t rdat;
      time   t_done;
      i_arst_n   = 1'b0;
      i_ibus_adr = '0;
      i_ibus_cyc = 1'b0;
      i_ibus_stb = 1'b0;
      i_dbus     = '0;
      build_stimulus();
      limit = 20 * stim.size() + 400;
      repeat (5) @(posedge i_wb_clk);
      #2;
      i_arst_n = 1'b1;
      check_flag("no ack after reset", 1'b0, o_ibus.ack | o_dbus.ack);
      check_flag("halt low after reset", 1'b0, o_halt);
      check_flag("irq low after reset", 1'b0, o_timer_irq);
      for (int r = 0; r < 4; r++) begin
         run_pair(next_random(), {MAP_RAM, 28'h100} + 4 * r);
      end
      foreach (stim[k]) begin
         bus_cycle(stim[k].use_dbus, stim[k].we, stim[k].adr, stim[k].dat, stim[k].sel,
                   rdat, t_done);
         if (!stim[k].we) begin
            check_data($sformatf("entry %0d read %h", k, stim[k].adr), stim[k].exp, rdat);
         end
      end
      check_char("printed character", print_word[7:0], last_char);
      check_flag("single print pulse", 1'b1, print_pulses == 1);
      check_flag("halt flag", 1'b1, o_halt);
      bus_cycle(DBUS, 1'b1, reg_addr(MAP_TIMER, TMR_MTIME), 32'd0, 4'b1111, rdat, t_done);
      bus_cycle(DBUS, 1'b1, reg_addr(MAP_TIMER, TMR_MTIMECMP), 32'd200, 4'b1111, rdat, t_done);
      check_flag("irq low after compare write", 1'b0, o_timer_irq);
      repeat (250) @(negedge i_wb_clk);
      check_flag("irq high past compare", 1'b1, o_timer_irq);
      bus_cycle(DBUS, 1'b0, reg_addr(MAP_TIMER, TMR_MTIME), 32'd0, 4'b1111, rdat, t_done);
      check_flag("mtime past compare", 1'b1, rdat > 32'd200);
      bus_cycle(DBUS, 1'b1, reg_addr(MAP_TIMER, TMR_MTIMECMP), '1, 4'b1111, rdat, t_done);
      repeat (2) @(negedge i_wb_clk);
      check_flag("irq cleared", 1'b0, o_timer_irq);
      $display("checks: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- tests/wb_soc_assert.sv
`timescale 1ns/1ps

module wb_soc_assert (
   input logic i_wb_clk,
   input logic i_arst_n,
   input logic i_ibus_cyc,
   input logic i_ibus_stb,
   input logic i_ibus_ack,
   input logic i_dbus_cyc,
   input logic i_dbus_stb,
   input logic i_dbus_ack,
   input logic i_halt
);

   acks_exclusive: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      !(i_ibus_ack && i_dbus_ack))
      else $error("ibus and dbus acknowledged in the same cycle");

   ibus_ack_in_cycle: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      i_ibus_ack |-> i_ibus_cyc)
      else $error("ibus ack without ibus cyc");

   dbus_ack_in_cycle: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      i_dbus_ack |-> i_dbus_cyc)
      else $error("dbus ack without dbus cyc");

   // a master alone on the bus sees its ack two cycles after the request
   ibus_latency: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      $rose(i_ibus_cyc && i_ibus_stb) && !i_dbus_cyc |-> ##1 !i_ibus_ack ##1 i_ibus_ack)
      else $error("ibus ack latency is not two cycles");

   dbus_latency: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      $rose(i_dbus_cyc && i_dbus_stb) && !i_ibus_cyc |-> ##1 !i_dbus_ack ##1 i_dbus_ack)
      else $error("dbus ack latency is not two cycles");

   halt_sticky: assert property (@(posedge i_wb_clk) disable iff (!i_arst_n)
      i_halt |=> i_halt)
      else $error("halt dropped without reset");

endmodule

bind wb_soc wb_soc_assert assert_i (
   .i_wb_clk   (i_wb_clk),
   .i_arst_n   (i_arst_n),
   .i_ibus_cyc (i_ibus_cyc),
   .i_ibus_stb (i_ibus_stb),
   .i_ibus_ack (o_ibus.ack),
   .i_dbus_cyc (i_dbus.cyc),
   .i_dbus_stb (i_dbus.stb),
   .i_dbus_ack (o_dbus.ack),
   .i_halt     (o_halt)
);

//--- design/wb_soc.sv
`timescale 1ns/1ps

module wb_soc import wb_soc_pkg::*; #(
   parameter int MEM_DEPTH = 16384   // words, power of two
) (
   input  logic    i_wb_clk,
   input  logic    i_arst_n,
   input  addr_t   i_ibus_adr,
   input  logic    i_ibus_cyc,
   input  logic    i_ibus_stb,
   output wb_s2m_t o_ibus,
   input  wb_m2s_t i_dbus,
   output wb_s2m_t o_dbus,
   output logic    o_timer_irq,
   output char_t   o_print_char,
   output logic    o_print_valid,
   output logic    o_halt
);

   wb_m2s_t ibus_m2s;
   wb_m2s_t bus_m2s;
   wb_s2m_t bus_s2m;
   wb_m2s_t ram_m2s;
   wb_s2m_t ram_s2m;
   wb_m2s_t sim_m2s;
   wb_s2m_t sim_s2m;
   wb_m2s_t tmr_m2s;
   wb_s2m_t tmr_s2m;

   // instruction fetch is a read-only full-word master
   always_comb begin
      ibus_m2s.adr = i_ibus_adr;
      ibus_m2s.dat = '0;
      ibus_m2s.sel = 4'b1111;
      ibus_m2s.we  = 1'b0;
      ibus_m2s.cyc = i_ibus_cyc;
      ibus_m2s.stb = i_ibus_stb;
   end

   bus_arbiter arbiter (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .i_ibus   (ibus_m2s),
      .o_ibus   (o_ibus),
      .i_dbus   (i_dbus),
      .o_dbus   (o_dbus),
      .o_bus    (bus_m2s),
      .i_bus    (bus_s2m)
   );

   addr_decoder decoder (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .i_bus    (bus_m2s),
      .o_bus    (bus_s2m),
      .o_ram    (ram_m2s),
      .o_sim    (sim_m2s),
      .o_tmr    (tmr_m2s),
      .i_ram    (ram_s2m),
      .i_sim    (sim_s2m),
      .i_tmr    (tmr_s2m)
   );

   wb_ram #(.MEM_DEPTH (MEM_DEPTH)) ram (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .i_bus    (ram_m2s),
      .o_bus    (ram_s2m)
   );

   sim_ctrl sim (
      .i_wb_clk      (i_wb_clk),
      .i_arst_n      (i_arst_n),
      .i_bus         (sim_m2s),
      .o_bus         (sim_s2m),
      .o_print_char  (o_print_char),
      .o_print_valid (o_print_valid),
      .o_halt        (o_halt)
   );

   riscv_timer timer (
      .i_wb_clk (i_wb_clk),
      .i_arst_n (i_arst_n),
      .i_bus    (tmr_m2s),
      .o_bus    (tmr_s2m),
      .o_irq    (o_timer_irq)
   );

endmodule

//--- timer/riscv_timer.sv
`timescale 1ns/1ps

module riscv_timer import wb_soc_pkg::*; (
   input  logic    i_wb_clk,
   input  logic    i_arst_n,
   input  wb_m2s_t i_bus,
   output wb_s2m_t o_bus,
   output logic    o_irq
);

   data_t      mtime;
   data_t      mtimecmp;
   data_t      rdat;
   logic       ack;
   logic       irq;
   logic       access;
   logic       wr;
   logic [1:0] offset;

   assign access = i_bus.cyc & i_bus.stb & !ack;
   assign wr     = access & i_bus.we;   // full word writes, sel is not looked at
   assign offset = i_bus.adr[3:2];

   // ************************************************************
   // counter and compare registers
   // ************************************************************

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime <= '0;
      end else if (wr && offset == TMR_MTIME) begin
         mtime <= i_bus.dat;
      end else begin
         mtime <= mtime + 32'd1;
      end
   end

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtimecmp <= '1;   // keeps the interrupt quiet out of reset
      end else if (wr && offset == TMR_MTIMECMP) begin
         mtimecmp <= i_bus.dat;
      end
   end

   // level interrupt, one cycle behind the registers it compares
   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         irq <= 1'b0;
      end else begin
         irq <= (mtime >= mtimecmp);
      end
   end

   // ************************************************************
   // bus response
   // ************************************************************

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= access;
      end
   end

   always_ff @(posedge i_wb_clk) begin
      if (access) begin
         case (offset)
            TMR_MTIME:    rdat <= mtime;
            TMR_MTIMECMP: rdat <= mtimecmp;
            default:      rdat <= '0;
         endcase
      end
   end

   assign o_bus.dat = rdat;
   assign o_bus.ack = ack;
   assign o_irq     = irq;

endmodule

//--- design/sim_ctrl.sv
`timescale 1ns/1ps

module sim_ctrl import wb_soc_pkg::*; (
   input  logic    i_wb_clk,
   input  logic    i_arst_n,
   input  wb_m2s_t i_bus,
   output wb_s2m_t o_bus,
   output char_t   o_print_char,
   output logic    o_print_valid,
   output logic    o_halt
);

   logic       access;
   logic       ack;
   logic [1:0] offset;
   data_t      rdat;
   char_t      print_char;
   logic       print_valid;
   logic       halt;

   assign access = i_bus.cyc & i_bus.stb & !ack;
   assign offset = i_bus.adr[3:2];

   // ************************************************************
   // control state
   // ************************************************************

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack         <= 1'b0;
         print_valid <= 1'b0;
         halt        <= 1'b0;
      end else begin
         ack         <= access;
         print_valid <= access & i_bus.we & (offset == SIM_PRINT);   // rises with ack
         if (access && i_bus.we && offset == SIM_HALT) begin
            halt <= 1'b1;   // only reset clears it
         end
      end
   end

   always_ff @(posedge i_wb_clk) begin
      if (access) begin
         if (i_bus.we && offset == SIM_PRINT) begin
            print_char <= i_bus.dat[7:0];
         end
         rdat <= (offset == SIM_HALT) ? {31'd0, halt} : '0;
      end
   end

   assign o_bus.dat     = rdat;
   assign o_bus.ack     = ack;
   assign o_print_char  = print_char;
   assign o_print_valid = print_valid;
   assign o_halt        = halt;

endmodule

//--- design/wb_ram.sv
`timescale 1ns/1ps

module wb_ram import wb_soc_pkg::*; #(
   parameter int MEM_DEPTH = 16384
) (
   input  logic    i_wb_clk,
   input  logic    i_arst_n,
   input  wb_m2s_t i_bus,
   output wb_s2m_t o_bus
);

   localparam int AW = $clog2(MEM_DEPTH);

   data_t          mem [MEM_DEPTH];
   logic [AW-1:0]  idx;
   logic           access;
   logic           ack;
   data_t          rdat;

   // upper address bits are dropped, so the array repeats across the region
   assign idx    = i_bus.adr[AW+1:2];
   assign access = i_bus.cyc & i_bus.stb & !ack;

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack <= 1'b0;
      end else begin
         ack <= access;
      end
   end

   always_ff @(posedge i_wb_clk) begin
      if (access) begin
         rdat <= mem[idx];   // old contents on a write cycle
         if (i_bus.we) begin
            for (int b = 0; b < 4; b++) begin
               if (i_bus.sel[b]) begin
                  mem[idx][8*b +: 8] <= i_bus.dat[8*b +: 8];
               end
            end
         end
      end
   end

   assign o_bus.dat = rdat;
   assign o_bus.ack = ack;

endmodule

//--- design/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder import wb_soc_pkg::*; (
   input  logic    i_wb_clk,
   input  logic    i_arst_n,
   input  wb_m2s_t i_bus,
   output wb_s2m_t o_bus,
   output wb_m2s_t o_ram,
   output wb_m2s_t o_sim,
   output wb_m2s_t o_tmr,
   input  wb_s2m_t i_ram,
   input  wb_s2m_t i_sim,
   input  wb_s2m_t i_tmr
);

   logic [3:0] region;
   logic       hit_ram;
   logic       hit_sim;
   logic       hit_tmr;
   logic       hit_none;
   logic       none_ack;   // our own answer for holes in the map

   assign region   = i_bus.adr[31:28];
   assign hit_ram  = (region == MAP_RAM);
   assign hit_sim  = (region == MAP_SIM);
   assign hit_tmr  = (region == MAP_TIMER);
   assign hit_none = !(hit_ram || hit_sim || hit_tmr);

   always_comb begin
      o_ram     = i_bus;
      o_sim     = i_bus;
      o_tmr     = i_bus;
      o_ram.stb = i_bus.stb & hit_ram;
      o_sim.stb = i_bus.stb & hit_sim;
      o_tmr.stb = i_bus.stb & hit_tmr;
   end

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         none_ack <= 1'b0;
      end else begin
         none_ack <= i_bus.cyc & i_bus.stb & hit_none & !none_ack;
      end
   end

   // adr is held for the whole cycle, so the response mux can follow it
   always_comb begin
      if (hit_ram) begin
         o_bus = i_ram;
      end else if (hit_sim) begin
         o_bus = i_sim;
      end else if (hit_tmr) begin
         o_bus = i_tmr;
      end else begin
         o_bus.dat = '0;
         o_bus.ack = none_ack;
      end
   end

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import wb_soc_pkg::*; (
   input  logic    i_wb_clk,
   input  logic    i_arst_n,
   input  wb_m2s_t i_ibus,
   output wb_s2m_t o_ibus,
   input  wb_m2s_t i_dbus,
   output wb_s2m_t o_dbus,
   output wb_m2s_t o_bus,
   input  wb_s2m_t i_bus
);

   arb_state_e state;
   logic       last_dbus;   // set when dbus got the most recent grant
   logic       ibus_req;
   logic       dbus_req;

   assign ibus_req = i_ibus.cyc & i_ibus.stb;
   assign dbus_req = i_dbus.cyc & i_dbus.stb;

   always_ff @(posedge i_wb_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state     <= ARB_IDLE;
         last_dbus <= 1'b0;   // so dbus wins the first tie
      end else begin
         case (state)
            ARB_IDLE: begin
               if (dbus_req && (!ibus_req || !last_dbus)) begin
                  state     <= ARB_DBUS;
                  last_dbus <= 1'b1;
               end else if (ibus_req) begin
                  state     <= ARB_IBUS;
                  last_dbus <= 1'b0;
               end
            end
            // the owner keeps the bus until it drops cyc
            ARB_IBUS: if (!i_ibus.cyc) state <= ARB_IDLE;
            ARB_DBUS: if (!i_dbus.cyc) state <= ARB_IDLE;
            default:  state <= ARB_IDLE;
         endcase
      end
   end

   // shared request, cyc and stb only come through for the owner
   always_comb begin
      o_bus = '0;
      case (state)
         ARB_IBUS: o_bus = i_ibus;
         ARB_DBUS: o_bus = i_dbus;
         default:  o_bus = '0;
      endcase
   end

   always_comb begin
      o_ibus.dat = i_bus.dat;
      o_ibus.ack = i_bus.ack & (state == ARB_IBUS);
      o_dbus.dat = i_bus.dat;
      o_dbus.ack = i_bus.ack & (state == ARB_DBUS);
   end

endmodule

//--- common/wb_soc_pkg.sv
package wb_soc_pkg;

   // ************************************************************
   // bus widths
   // ************************************************************

   typedef logic [31:0] addr_t;   // byte address
   typedef logic [31:0] data_t;
   typedef logic [3:0]  sel_t;    // one bit per byte lane
   typedef logic [7:0]  char_t;

   // ************************************************************
   // wishbone classic link, one struct per direction
   // ************************************************************

   typedef struct packed {
      addr_t adr;
      data_t dat;
      sel_t  sel;
      logic  we;
      logic  cyc;
      logic  stb;
   } wb_m2s_t;

   typedef struct packed {
      data_t dat;
      logic  ack;
   } wb_s2m_t;

   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,
      ARB_IBUS = 2'd1,
      ARB_DBUS = 2'd2
   } arb_state_e;

   // slave select on adr[31:28]
   localparam logic [3:0] MAP_RAM   = 4'h8;
   localparam logic [3:0] MAP_SIM   = 4'h9;
   localparam logic [3:0] MAP_TIMER = 4'hA;

   // register offsets on adr[3:2]
   localparam logic [1:0] SIM_PRINT    = 2'd0;
   localparam logic [1:0] SIM_HALT     = 2'd1;
   localparam logic [1:0] TMR_MTIME    = 2'd0;
   localparam logic [1:0] TMR_MTIMECMP = 2'd1;

endpackage
